//--- hdl/rcc_eth_cfg.svh
`ifndef RCC_ETH_CFG_SVH
`define RCC_ETH_CFG_SVH

// ================================================
// apb bus widths
// ================================================
`define RCC_APB_AW 8
`define RCC_APB_DW 32

// register byte offsets
`define RCC_C1_ENR_OFS   'h00
`define RCC_C1_LPENR_OFS 'h04
`define RCC_C2_ENR_OFS   'h08
`define RCC_C2_LPENR_OFS 'h0C

// ================================================
// clock source
// ================================================
// rmii divide ratios for 100 and 10 Mb/s
`define RCC_ETH_DIV_FAST 2
`define RCC_ETH_DIV_SLOW 20

// depth of the synchronizer chains
`define RCC_SYNC_STAGES 2

`endif

//--- hdl/rcc_reg_pkg.sv
`default_nettype none

`include "rcc_eth_cfg.svh"

package rcc_reg_pkg;

  // apb address and data vectors
  typedef logic [`RCC_APB_AW-1:0] apb_addr_t;
  typedef logic [`RCC_APB_DW-1:0] apb_data_t;

  // one apb request, master to slave
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // one bit per ethernet kernel clock
  // rx sits in bit 0 and tx in bit 1, as in the registers
  typedef struct packed {
    logic tx;
    logic rx;
  } eth_clk_bits_t;

  // enable and low-power enable pair of one core
  typedef struct packed {
    eth_clk_bits_t en;
    eth_clk_bits_t lpen;
  } core_clk_cfg_t;

endpackage

`default_nettype wire

//--- hdl/rcc_clk_pkg.sv
`default_nettype none

package rcc_clk_pkg;

  // ================================================
  // core power state
  // ================================================
  // sleep keeps a clock only with lpen set
  // deepsleep stops every clock of that core
  typedef struct packed {
    logic sleep;
    logic deepsleep;
  } core_pm_t;

  // ================================================
  // kernel clock gate requests
  // ================================================
  typedef struct packed {
    logic tx;
    logic rx;
    // rmii reference clock
    logic rmii_ref;
  } eth_ker_en_t;

endpackage

`default_nettype wire

//--- hdl/rcc_eth_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "rcc_eth_cfg.svh"

module rcc_eth_apb_regs
  import rcc_reg_pkg::*;
(
  input  logic          rcc_pclk,
  input  logic          rst_n,
  input  apb_req_t      apb_req,
  output apb_data_t     prdata,
  output logic          pslverr,
  output core_clk_cfg_t c1_cfg,
  output core_clk_cfg_t c2_cfg
);

  logic          acc_cycle;
  logic          wr_en;
  logic          rd_en;
  logic          sel_c1_enr;
  logic          sel_c1_lpenr;
  logic          sel_c2_enr;
  logic          sel_c2_lpenr;
  logic          addr_hit;
  eth_clk_bits_t wr_bits;
  eth_clk_bits_t rd_bits;
  eth_clk_bits_t c1_en_q;
  eth_clk_bits_t c1_lpen_q;
  eth_clk_bits_t c2_en_q;
  eth_clk_bits_t c2_lpen_q;

  // ================================================
  // transfer qualification
  // ================================================
  // zero-wait slave, every access ends in its access cycle
  assign acc_cycle = apb_req.psel & apb_req.penable;
  assign wr_en     = acc_cycle & apb_req.pwrite & addr_hit;
  assign rd_en     = acc_cycle & ~apb_req.pwrite;

  // offset decode
  assign sel_c1_enr   = (apb_req.paddr == apb_addr_t'(`RCC_C1_ENR_OFS));
  assign sel_c1_lpenr = (apb_req.paddr == apb_addr_t'(`RCC_C1_LPENR_OFS));
  assign sel_c2_enr   = (apb_req.paddr == apb_addr_t'(`RCC_C2_ENR_OFS));
  assign sel_c2_lpenr = (apb_req.paddr == apb_addr_t'(`RCC_C2_LPENR_OFS));
  assign addr_hit     = sel_c1_enr | sel_c1_lpenr | sel_c2_enr | sel_c2_lpenr;

  // only bits 1:0 exist, rx in bit 0
  assign wr_bits = eth_clk_bits_t'(apb_req.pwdata[1:0]);

  // ================================================
  // register storage
  // ================================================
  always_ff @(posedge rcc_pclk) begin
    if (!rst_n) begin
      c1_en_q   <= '0;
      c1_lpen_q <= '0;
      c2_en_q   <= '0;
      c2_lpen_q <= '0;
    end else if (wr_en) begin
      if (sel_c1_enr) begin
        c1_en_q <= wr_bits;
      end
      if (sel_c1_lpenr) begin
        c1_lpen_q <= wr_bits;
      end
      if (sel_c2_enr) begin
        c2_en_q <= wr_bits;
      end
      if (sel_c2_lpenr) begin
        c2_lpen_q <= wr_bits;
      end
    end
  end

  // ================================================
  // read data and slave error
  // ================================================
  always_comb begin
    rd_bits = '0;
    if (sel_c1_enr) begin
      rd_bits = c1_en_q;
    end
    if (sel_c1_lpenr) begin
      rd_bits = c1_lpen_q;
    end
    if (sel_c2_enr) begin
      rd_bits = c2_en_q;
    end
    if (sel_c2_lpenr) begin
      rd_bits = c2_lpen_q;
    end
  end

  // upper bits read zero, unmapped offsets read zero
  assign prdata  = rd_en ? apb_data_t'(rd_bits) : '0;
  assign pslverr = acc_cycle & ~addr_hit;

  assign c1_cfg = '{en: c1_en_q, lpen: c1_lpen_q};
  assign c2_cfg = '{en: c2_en_q, lpen: c2_lpen_q};

endmodule

`default_nettype wire

//--- hdl/rcc_eth_clk_en.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_eth_clk_en
  import rcc_reg_pkg::*;
  import rcc_clk_pkg::*;
(
  input  core_clk_cfg_t c1_cfg,
  input  core_clk_cfg_t c2_cfg,
  input  core_pm_t      c1_pm,
  input  core_pm_t      c2_pm,
  output eth_ker_en_t   ker_en
);

  eth_clk_bits_t c1_req;
  eth_clk_bits_t c2_req;

  // request of one clock from one core
  function automatic logic core_req(
    input logic     en,
    input logic     lpen,
    input core_pm_t pm
  );
    return en & (~pm.sleep | lpen) & ~pm.deepsleep;
  endfunction

  // ================================================
  // per-core requests
  // ================================================
  assign c1_req.tx = core_req(c1_cfg.en.tx, c1_cfg.lpen.tx, c1_pm);
  assign c1_req.rx = core_req(c1_cfg.en.rx, c1_cfg.lpen.rx, c1_pm);
  assign c2_req.tx = core_req(c2_cfg.en.tx, c2_cfg.lpen.tx, c2_pm);
  assign c2_req.rx = core_req(c2_cfg.en.rx, c2_cfg.lpen.rx, c2_pm);

  // either core keeps a clock alive
  assign ker_en.tx = c1_req.tx | c2_req.tx;
  assign ker_en.rx = c1_req.rx | c2_req.rx;

  // reference clock runs with any mii clock
  assign ker_en.rmii_ref = ker_en.tx | ker_en.rx;

endmodule

`default_nettype wire

//--- hdl/rcc_eth_clk_src.sv
`timescale 1ns/100ps
`default_nettype none

`include "rcc_eth_cfg.svh"

module rcc_eth_clk_src (
  input  logic rst_n,
  input  logic pad_rcc_eth_mii_tx_clk,
  input  logic pad_rcc_eth_mii_rx_clk,
  input  logic eth_rcc_fes,
  input  logic eth_rcc_epis_2,
  output logic tx_clk_pre,
  output logic rx_clk_pre
);

  localparam int unsigned SYNC_N    = `RCC_SYNC_STAGES;
  localparam int unsigned HALF_FAST = `RCC_ETH_DIV_FAST / 2;
  localparam int unsigned HALF_SLOW = `RCC_ETH_DIV_SLOW / 2;
  localparam int unsigned CNT_W     = $clog2(HALF_SLOW);

  logic [SYNC_N-1:0] rst_sync_q;
  logic              rx_rst_n;
  logic [SYNC_N-1:0] fes_sync_q;
  logic              fes_s;
  logic [CNT_W-1:0]  div_cnt_q;
  logic [CNT_W-1:0]  div_last;
  logic              div_clk_q;
  logic [1:0]        pad_clk;
  logic [1:0]        sw_clk;

  // ================================================
  // reset synchronizer, rx pad domain
  // ================================================
  always_ff @(posedge pad_rcc_eth_mii_rx_clk) begin
    if (!rst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[SYNC_N-2:0], 1'b1};
    end
  end

  assign rx_rst_n = rst_sync_q[SYNC_N-1];

  // ================================================
  // speed select synchronizer
  // ================================================
  always_ff @(posedge pad_rcc_eth_mii_rx_clk) begin
    if (!rx_rst_n) begin
      fes_sync_q <= '0;
    end else begin
      fes_sync_q <= {fes_sync_q[SYNC_N-2:0], eth_rcc_fes};
    end
  end

  assign fes_s = fes_sync_q[SYNC_N-1];

  // ================================================
  // rmii divider, /2 or /20
  // ================================================
  // counts half periods, toggles at the last count
  assign div_last = fes_s ? CNT_W'(HALF_FAST - 1) : CNT_W'(HALF_SLOW - 1);

  always_ff @(posedge pad_rcc_eth_mii_rx_clk) begin
    if (!rx_rst_n) begin
      div_cnt_q <= '0;
      div_clk_q <= 1'b0;
    end else if (div_cnt_q >= div_last) begin
      // >= also catches a ratio change mid-count
      div_cnt_q <= '0;
      div_clk_q <= ~div_clk_q;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // ================================================
  // glitch-free switches, pad clock vs divided clock
  // ================================================
  // index 0 is tx, index 1 is rx
  assign pad_clk = {pad_rcc_eth_mii_rx_clk, pad_rcc_eth_mii_tx_clk};

  for (genvar i = 0; i < 2; i++) begin : g_sw
    logic [1:0] pad_en_q;
    logic [1:0] div_en_q;

    // pad branch, enabled while epis_2 low
    always_ff @(negedge pad_clk[i]) begin
      if (!rst_n) begin
        pad_en_q <= '0;
      end else begin
        pad_en_q <= {pad_en_q[0], ~eth_rcc_epis_2 & ~div_en_q[1]};
      end
    end

    // divided branch, waits for the pad branch to drop
    always_ff @(negedge div_clk_q) begin
      if (!rst_n) begin
        div_en_q <= '0;
      end else begin
        div_en_q <= {div_en_q[0], eth_rcc_epis_2 & ~pad_en_q[1]};
      end
    end

    // enables move only while their clock is low
    assign sw_clk[i] = (pad_clk[i] & pad_en_q[1]) | (div_clk_q & div_en_q[1]);
  end

  assign tx_clk_pre = sw_clk[0];
  assign rx_clk_pre = sw_clk[1];

endmodule

`default_nettype wire

//--- hdl/rcc_eth_clk_gate.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_eth_clk_gate (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  input  logic rst_n,
  output logic gen_clk
);

  logic en_lat;

  // ================================================
  // enable latch, open in the low phase
  // ================================================
  always_latch begin
    if (!rst_n) begin
      en_lat <= 1'b0;
    end else if (!raw_clk) begin
      // test mode forces the clock through
      en_lat <= active | bypass;
    end
  end

  // latched enable never changes in a high phase
  assign gen_clk = raw_clk & en_lat;

endmodule

`default_nettype wire

//--- hdl/rcc_eth_ker_clk_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rcc_eth_ker_clk_ctrl
  import rcc_reg_pkg::*;
  import rcc_clk_pkg::*;
(
  // apb slave
  input  logic      rcc_pclk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pslverr,
  // pad clocks and mac controls
  input  logic      pad_rcc_eth_mii_tx_clk,
  input  logic      pad_rcc_eth_mii_rx_clk,
  input  logic      eth_rcc_fes,
  input  logic      eth_rcc_epis_2,
  // core power modes
  input  core_pm_t  c1_pm,
  input  core_pm_t  c2_pm,
  input  logic      testmode,
  // kernel clocks
  output logic      rcc_eth_mii_tx_clk,
  output logic      rcc_eth_mii_rx_clk,
  output logic      rcc_eth_rmii_ref_clk
);

  apb_req_t      apb_req;
  core_clk_cfg_t c1_cfg;
  core_clk_cfg_t c2_cfg;
  eth_ker_en_t   ker_en;
  logic          tx_clk_pre;
  logic          rx_clk_pre;

  assign apb_req = '{
    psel:    psel,
    penable: penable,
    pwrite:  pwrite,
    paddr:   paddr,
    pwdata:  pwdata
  };

  // ================================================
  // registers and enable logic
  // ================================================
  rcc_eth_apb_regs u_apb_regs (
    .rcc_pclk(rcc_pclk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .prdata  (prdata),
    .pslverr (pslverr),
    .c1_cfg  (c1_cfg),
    .c2_cfg  (c2_cfg)
  );

  rcc_eth_clk_en u_clk_en (
    .c1_cfg(c1_cfg),
    .c2_cfg(c2_cfg),
    .c1_pm (c1_pm),
    .c2_pm (c2_pm),
    .ker_en(ker_en)
  );

  // ================================================
  // clock sources and gates
  // ================================================
  rcc_eth_clk_src u_clk_src (
    .rst_n                 (rst_n),
    .pad_rcc_eth_mii_tx_clk(pad_rcc_eth_mii_tx_clk),
    .pad_rcc_eth_mii_rx_clk(pad_rcc_eth_mii_rx_clk),
    .eth_rcc_fes           (eth_rcc_fes),
    .eth_rcc_epis_2        (eth_rcc_epis_2),
    .tx_clk_pre            (tx_clk_pre),
    .rx_clk_pre            (rx_clk_pre)
  );

  // each gate takes its own request
  rcc_eth_clk_gate u_tx_clk_gate (
    .raw_clk(tx_clk_pre),
    .active (ker_en.tx),
    .bypass (testmode),
    .rst_n  (rst_n),
    .gen_clk(rcc_eth_mii_tx_clk)
  );

  rcc_eth_clk_gate u_rx_clk_gate (
    .raw_clk(rx_clk_pre),
    .active (ker_en.rx),
    .bypass (testmode),
    .rst_n  (rst_n),
    .gen_clk(rcc_eth_mii_rx_clk)
  );

  // reference clock comes straight from the rx pad
  rcc_eth_clk_gate u_ref_clk_gate (
    .raw_clk(pad_rcc_eth_mii_rx_clk),
    .active (ker_en.rmii_ref),
    .bypass (testmode),
    .rst_n  (rst_n),
    .gen_clk(rcc_eth_rmii_ref_clk)
  );

endmodule

`default_nettype wire

//--- test/tb_rcc_eth_ker_clk_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "rcc_eth_cfg.svh"

module tb_rcc_eth_ker_clk_ctrl
  import rcc_reg_pkg::*;
  import rcc_clk_pkg::*;
();

  localparam real HALF_PAD = 20.0;
  localparam int  SETTLE   = 10;

  logic      rcc_pclk;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pslverr;
  logic      pad_tx_clk;
  logic      pad_rx_clk;
  logic      fes;
  logic      epis_2;
  logic      testmode;
  core_pm_t  c1_pm;
  core_pm_t  c2_pm;
  logic      tx_clk;
  logic      rx_clk;
  logic      ref_clk;

  int          seed = 32'h0047_e27b;
  logic [31:0] rnd;
  logic [1:0]  regs_sh [4];
  logic        pulse_chk = 1'b0;
  real         tx_last = 0.0;
  real         rx_last = 0.0;

  // free-running edge counters
  // windows take differences
  int tx_edges = 0;
  int rx_edges = 0;
  int ref_edges = 0;
  int txp_edges = 0;
  int rxp_edges = 0;
  int win_tx;
  int win_rx;
  int win_ref;
  int win_txp;
  int win_rxp;

  rcc_eth_ker_clk_ctrl rcc_eth_ker_clk_ctrl_i (
    .rcc_pclk              (rcc_pclk),
    .rst_n                 (rst_n),
    .psel                  (psel),
    .penable               (penable),
    .pwrite                (pwrite),
    .paddr                 (paddr),
    .pwdata                (pwdata),
    .prdata                (prdata),
    .pslverr               (pslverr),
    .pad_rcc_eth_mii_tx_clk(pad_tx_clk),
    .pad_rcc_eth_mii_rx_clk(pad_rx_clk),
    .eth_rcc_fes           (fes),
    .eth_rcc_epis_2        (epis_2),
    .c1_pm                 (c1_pm),
    .c2_pm                 (c2_pm),
    .testmode              (testmode),
    .rcc_eth_mii_tx_clk    (tx_clk),
    .rcc_eth_mii_rx_clk    (rx_clk),
    .rcc_eth_rmii_ref_clk  (ref_clk)
  );

  // ================================================
  // clocks and edge counters
  // ================================================
  initial begin
    rcc_pclk = 1'b0;
    forever #50 rcc_pclk = ~rcc_pclk;
  end

  initial begin
    pad_rx_clk = 1'b0;
    forever #20 pad_rx_clk = ~pad_rx_clk;
  end

  // tx pad lags rx pad by 7 ns
  initial begin
    pad_tx_clk = 1'b0;
    #7;
    forever #20 pad_tx_clk = ~pad_tx_clk;
  end

  always @(posedge tx_clk) tx_edges <= tx_edges + 1;
  always @(posedge rx_clk) rx_edges <= rx_edges + 1;
  always @(posedge ref_clk) ref_edges <= ref_edges + 1;
  always @(posedge pad_tx_clk) txp_edges <= txp_edges + 1;
  always @(posedge pad_rx_clk) rxp_edges <= rxp_edges + 1;

  // pulse width watch while the switches move
  always @(tx_clk) begin
    if (pulse_chk) begin
      assert ($realtime - tx_last >= HALF_PAD - 0.5) else
        halt_run("tx output pulse shorter than half a pad period");
    end
    tx_last = $realtime;
  end

  always @(rx_clk) begin
    if (pulse_chk) begin
      assert ($realtime - rx_last >= HALF_PAD - 0.5) else
        halt_run("rx output pulse shorter than half a pad period");
    end
    rx_last = $realtime;
  end

  // ================================================
  // checking helpers
  // ================================================
  task automatic halt_run(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual,
                             input int tol);
    assert ((actual >= expected - tol) && (actual <= expected + tol)) else
      halt_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
  endtask

  function automatic apb_addr_t reg_ofs(input int idx);
    case (idx)
      0:       return apb_addr_t'(`RCC_C1_ENR_OFS);
      1:       return apb_addr_t'(`RCC_C1_LPENR_OFS);
      2:       return apb_addr_t'(`RCC_C2_ENR_OFS);
      default: return apb_addr_t'(`RCC_C2_LPENR_OFS);
    endcase
  endfunction

  // deepsleep blocks a request and sleep needs lpen
  function automatic logic core_wants(input logic en, input logic lpen, input core_pm_t pm);
    if (pm.deepsleep) return 1'b0;
    if (pm.sleep) return en & lpen;
    return en;
  endfunction

  // b is 0 for rx and 1 for tx
  function automatic int clk_wanted(input int b);
    return int'(core_wants(regs_sh[0][b], regs_sh[1][b], c1_pm) |
                core_wants(regs_sh[2][b], regs_sh[3][b], c2_pm));
  endfunction

  // ================================================
  // apb and stimulus tasks
  // ================================================
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(posedge rcc_pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge rcc_pclk);
    #1;
    penable = 1'b1;
    @(negedge rcc_pclk);
    err = pslverr;
    @(posedge rcc_pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge rcc_pclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge rcc_pclk);
    #1;
    penable = 1'b1;
    @(negedge rcc_pclk);
    data = prdata;
    err  = pslverr;
    @(posedge rcc_pclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input int idx, input apb_data_t data);
    logic err;
    apb_write(reg_ofs(idx), data, err);
    check_value($sformatf("write pslverr %0d", idx), 0, int'(err), 0);
    regs_sh[idx] = data[1:0];
  endtask

  task automatic set_pm(input core_pm_t p1, input core_pm_t p2);
    @(posedge rcc_pclk);
    #1;
    c1_pm = p1;
    c2_pm = p2;
  endtask

  // counts edges over a number of rx pad cycles
  // sampling stays half a ns off the edges
  task automatic measure_window(input int cycles);
    int tx0;
    int rx0;
    int ref0;
    int txp0;
    int rxp0;
    int waited;
    #0.5;
    tx0    = tx_edges;
    rx0    = rx_edges;
    ref0   = ref_edges;
    txp0   = txp_edges;
    rxp0   = rxp_edges;
    waited = 0;
    while ((rxp_edges - rxp0 < cycles) && (waited < cycles * 80 + 100)) begin
      #1;
      waited++;
    end
    if (rxp_edges - rxp0 < cycles) begin
      halt_run("timeout while waiting for rx pad clock edges");
    end
    win_tx  = tx_edges - tx0;
    win_rx  = rx_edges - rx0;
    win_ref = ref_edges - ref0;
    win_txp = txp_edges - txp0;
    win_rxp = rxp_edges - rxp0;
  endtask

  task automatic check_clocks(input string name, input int etx, input int erx, input int eref);
    measure_window(SETTLE);
    measure_window(40);
    check_value({name, " tx"}, etx, int'(win_tx != 0), 0);
    check_value({name, " rx"}, erx, int'(win_rx != 0), 0);
    check_value({name, " ref"}, eref, int'(win_ref != 0), 0);
  endtask

  // ================================================
  // test sequence
  // ================================================
  initial begin
    apb_data_t rd;
    logic      err;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    fes      = 1'b0;
    epis_2   = 1'b0;
    testmode = 1'b0;
    c1_pm    = '0;
    c2_pm    = '0;
    repeat (2) @(posedge rcc_pclk);
    #1;
    rst_n = 1'b1;

    // register access
    for (int i = 0; i < 4; i++) begin
      apb_read(reg_ofs(i), rd, err);
      check_value($sformatf("reset value %0d", i), 0, int'(rd), 0);
      check_value($sformatf("reset pslverr %0d", i), 0, int'(err), 0);
    end
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      write_reg(i, rnd);
      apb_read(reg_ofs(i), rd, err);
      check_value($sformatf("readback %0d", i), int'(rnd[1:0]), int'(rd), 0);
    end
    apb_write(8'h10, 32'hffff_ffff, err);
    check_value("unmapped write pslverr", 1, int'(err), 0);
    apb_read(8'h10, rd, err);
    check_value("unmapped read data", 0, int'(rd), 0);
    check_value("unmapped read pslverr", 1, int'(err), 0);
    for (int i = 0; i < 4; i++) begin
      apb_read(reg_ofs(i), rd, err);
      check_value($sformatf("after unmapped %0d", i), int'(regs_sh[i]), int'(rd), 0);
    end

    // random enables and power modes
    repeat (12) begin
      for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        write_reg(i, rnd);
      end
      rnd = $random(seed);
      set_pm(rnd[1:0], rnd[3:2]);
      check_clocks("enable rule", clk_wanted(1), clk_wanted(0),
                   clk_wanted(0) | clk_wanted(1));
    end

    // low power with core 1 owning both clocks
    write_reg(0, 32'h3);
    write_reg(1, 32'h0);
    write_reg(2, 32'h0);
    write_reg(3, 32'h0);
    set_pm(2'b00, 2'b00);
    check_clocks("c1 awake", 1, 1, 1);
    set_pm(2'b10, 2'b00);
    check_clocks("c1 sleep", 0, 0, 0);
    write_reg(1, 32'h3);
    check_clocks("c1 sleep lpen", 1, 1, 1);
    set_pm(2'b11, 2'b00);
    check_clocks("c1 deepsleep", 0, 0, 0);
    write_reg(2, 32'h2);
    check_clocks("c2 keeps tx", 1, 0, 1);

    // test bypass
    for (int i = 0; i < 4; i++) begin
      write_reg(i, 32'h0);
    end
    set_pm(2'b00, 2'b00);
    @(posedge rcc_pclk);
    #1;
    testmode = 1'b1;
    check_clocks("testmode on", 1, 1, 1);
    @(posedge rcc_pclk);
    #1;
    testmode = 1'b0;
    check_clocks("testmode off", 0, 0, 0);

    // rmii speed with the divided clock on both outputs
    write_reg(0, 32'h3);
    @(posedge rcc_pclk);
    #1;
    fes    = 1'b1;
    epis_2 = 1'b1;
    measure_window(120);
    measure_window(400);
    check_value("rmii 100 tx", win_rxp / `RCC_ETH_DIV_FAST, win_tx, 2);
    check_value("rmii 100 rx", win_rxp / `RCC_ETH_DIV_FAST, win_rx, 2);
    @(posedge rcc_pclk);
    #1;
    fes = 1'b0;
    measure_window(120);
    measure_window(400);
    check_value("rmii 10 tx", win_rxp / `RCC_ETH_DIV_SLOW, win_tx, 2);
    check_value("rmii 10 rx", win_rxp / `RCC_ETH_DIV_SLOW, win_rx, 2);

    // back to mii with pulse width watch
    pulse_chk = 1'b1;
    @(posedge rcc_pclk);
    #1;
    epis_2 = 1'b0;
    measure_window(120);
    measure_window(400);
    check_value("mii tx", win_txp, win_tx, 2);
    check_value("mii rx", win_rxp, win_rx, 2);
    pulse_chk = 1'b0;

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/rcc_reg_pkg.sv
hdl/rcc_clk_pkg.sv
hdl/rcc_eth_apb_regs.sv
hdl/rcc_eth_clk_en.sv
hdl/rcc_eth_clk_src.sv
hdl/rcc_eth_clk_gate.sv
hdl/rcc_eth_ker_clk_ctrl.sv
test/tb_rcc_eth_ker_clk_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_rcc_eth_ker_clk_ctrl
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
